// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_rx
FILELIST = all.f
OBJ_DIR  = obj_dir
PASS_MSG = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+bench
design/rx_pkg.sv
design/rx_cfg.sv
design/rx_remap.sv
design/rx_timeout.sv
design/rx_top.sv
bench/tb_rx.sv

// ==== bench/tb_rx_model.svh ====
// reference model for the rx config path
// mirrors registers, remap rule, test accumulator, taps and idle limits

`ifndef TB_RX_MODEL_SVH
`define TB_RX_MODEL_SVH

rx_pkg::rx_cfg_t  m_cfg      = '0;
rx_pkg::word_t    m_base     = '0;
rx_pkg::word_t    m_testdata = '0;
rx_pkg::status_t  m_status   = '0;
rx_pkg::word_t    m_tap0     = '0;
logic [12:0]      m_tap1     = '0;   // word 1 bits 44..32

// register side effects of one memory-interface write
function automatic void model_write(input logic [3:0] idx, input rx_pkg::word_t d);
   case (idx)
      rx_pkg::REG_CFG:      m_cfg = rx_pkg::rx_cfg_t'(d);
      rx_pkg::REG_OFFSET:   m_base = d;
      rx_pkg::REG_IDELAY0:  m_tap0 = d;
      rx_pkg::REG_IDELAY1:  m_tap1 = d[12:0];
      rx_pkg::REG_TESTDATA: m_testdata = d;
      rx_pkg::REG_STATUS:   m_status = d[15:0];
      default: ;                             // read-only or unmapped
   endcase
endfunction

// expected downstream address for an input address
function automatic rx_pkg::word_t expect_addr(input rx_pkg::word_t addr);
   rx_pkg::word_t a;
   a = addr;
   if (m_cfg.remap_mode == rx_pkg::REMAP_STATIC) begin
      for (int b = 0; b < 12; b++)
         if (m_cfg.remap_sel[b])
            a[20+b] = m_cfg.remap_pattern[b];   // selected upper bits replaced
   end else if (m_cfg.remap_mode == rx_pkg::REMAP_DYNAMIC) begin
      a = addr + m_base;                        // wraps mod 2^32
   end
   return a;
endfunction

// nine 5-bit fields, frame on top
function automatic rx_pkg::taps_t expect_taps();
   rx_pkg::taps_t t;
   t = '0;
   for (int f = 0; f < 8; f++) begin
      t[5*f+4]    = m_tap1[4+f];                // msb from word 1 bit 36+f
      t[5*f +: 4] = m_tap0[4*f +: 4];
   end
   t[44]    = m_tap1[12];
   t[43:40] = m_tap1[3:0];
   return t;
endfunction

// idle cycles before a timeout pulse
function automatic int idle_limit(input logic [1:0] timer_cfg);
   case (timer_cfg)
      2'd1:    return 63;
      2'd2:    return 255;
      2'd3:    return 1023;
      default: return 0;                        // timer off
   endcase
endfunction

`endif

// ==== bench/tb_rx.sv ====
// rx configuration path testbench
// random register, remap, test mode, status, timeout and tap checks vs a model

`timescale 1ns/100ps

module tb_rx;

   localparam int RESET_CYCLES = 10;
   localparam int N_RAND       = 40;     // iterations per random loop
   // rough cycle count of all tests, sizes the watchdog
   localparam int TEST_CYCLES  = RESET_CYCLES + N_RAND * 16 + 4 * (N_RAND + 10) + 600;

   logic                clk;
   logic                nreset;
   logic                mi_en;
   logic                mi_we;
   rx_pkg::mi_addr_t    mi_addr;
   rx_pkg::word_t       mi_din;
   rx_pkg::word_t       mi_dout;
   rx_pkg::rx_access_t  rx_in;
   rx_pkg::rx_access_t  rx_out;
   rx_pkg::gpio_t       gpio_datain;
   logic [13:0]         ext_status;
   logic                mmu_enable;
   logic                mailbox_irq_en;
   rx_pkg::taps_t       idelay_value;
   logic                load_taps;
   int                  seed;

   `include "tb_rx_model.svh"

   rx_top i_dut (.*);

   always #4 clk = ~clk;   // 8 ns period

   //##########################################################################
   // checks
   //##########################################################################
   task automatic stop_on_error();
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input rx_pkg::word_t got, input rx_pkg::word_t exp,
                             input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_access(input rx_pkg::rx_access_t got,
                               input rx_pkg::rx_access_t exp, input string what);
      if (got.valid !== exp.valid ||
          (exp.valid && (got.addr !== exp.addr || got.data !== exp.data))) begin
         $display("[FAIL] %0t ns: %s got v=%b a=%h d=%h, expected v=%b a=%h d=%h",
                  $time, what, got.valid, got.addr, got.data, exp.valid, exp.addr, exp.data);
         stop_on_error();
      end
   endtask

   task automatic check_taps(input rx_pkg::taps_t got, input rx_pkg::taps_t exp,
                             input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, exp);
         stop_on_error();
      end
   endtask

   //##########################################################################
   // drivers, entered and left on a falling edge
   //##########################################################################
   function automatic rx_pkg::word_t rand_word();
      return $random(seed);
   endfunction

   task automatic write_reg(input logic [3:0] idx, input rx_pkg::word_t d);
      rx_pkg::word_t r;
      r       = rand_word();
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = {r[8:0], idx, 2'b00};          // upper address bits ignored
      mi_din  = d;
      @(negedge clk);
      mi_en   = 1'b0;
      model_write(idx, d);
   endtask

   task automatic read_check(input logic [3:0] idx, input rx_pkg::word_t exp,
                             input string what);
      mi_en   = 1'b1;
      mi_we   = 1'b0;
      mi_addr = {9'd0, idx, 2'b00};
      @(negedge clk);
      mi_en   = 1'b0;
      check_word(mi_dout, exp, what);
      @(negedge clk);
      check_word(mi_dout, 32'd0, "mi_dout after idle cycle");   // no read, no data
   endtask

   task automatic send_access(input rx_pkg::word_t addr, input rx_pkg::word_t data);
      rx_pkg::rx_access_t exp;
      exp = '0;
      if (m_cfg.test_mode) begin
         m_testdata  = m_testdata + data;      // diverted into the sum
         m_status[1] = 1'b1;
      end else begin
         exp.valid = 1'b1;
         exp.addr  = expect_addr(addr);
         exp.data  = data;
      end
      rx_in.valid = 1'b1;
      rx_in.addr  = addr;
      rx_in.data  = data;
      @(negedge clk);
      rx_in = '0;
      check_access(rx_out, exp, "rx_out");
   endtask

   //##########################################################################
   // tests
   //##########################################################################
   task automatic test_registers();
      rx_pkg::rx_cfg_t c;
      rx_pkg::word_t   v;
      for (int n = 0; n < N_RAND; n++) begin
         c           = rx_pkg::rx_cfg_t'(rand_word());
         c.test_mode = 1'b0;                   // keep the access path quiet
         c.timer_cfg = 2'd0;
         write_reg(rx_pkg::REG_CFG, rx_pkg::word_t'(c));
         read_check(rx_pkg::REG_CFG, rx_pkg::word_t'(m_cfg), "cfg readback");
         check_word({31'd0, mmu_enable}, {31'd0, m_cfg.mmu_enable}, "mmu_enable");
         check_word({31'd0, mailbox_irq_en}, {31'd0, m_cfg.mailbox_irq_en}, "irq_en");
         write_reg(rx_pkg::REG_OFFSET, rand_word());
         read_check(rx_pkg::REG_OFFSET, m_base, "offset readback");
         write_reg(rx_pkg::REG_TESTDATA, rand_word());
         read_check(rx_pkg::REG_TESTDATA, m_testdata, "test data readback");
         v           = rand_word();
         gpio_datain = v[8:0];
         @(negedge clk);                       // let the sample land
         read_check(rx_pkg::REG_GPIO, {23'd0, gpio_datain}, "gpio readback");
         if (v[15:12] > 4'd6)
            read_check(v[15:12], 32'd0, "unmapped readback");
      end
   endtask

   task automatic test_remap();
      rx_pkg::rx_cfg_t c;
      for (int m = 0; m < 4; m++) begin        // none, static, dynamic, rsvd
         c            = rx_pkg::rx_cfg_t'(rand_word());
         c.test_mode  = 1'b0;
         c.timer_cfg  = 2'd0;
         c.remap_mode = rx_pkg::remap_mode_t'(m[1:0]);
         write_reg(rx_pkg::REG_OFFSET, rand_word());
         write_reg(rx_pkg::REG_CFG, rx_pkg::word_t'(c));
         for (int n = 0; n < N_RAND; n++)
            send_access(rand_word(), rand_word());   // back to back
      end
   endtask

   task automatic test_mode_accum();
      rx_pkg::rx_cfg_t c;
      c           = '0;
      c.test_mode = 1'b1;
      write_reg(rx_pkg::REG_STATUS, 32'd0);
      write_reg(rx_pkg::REG_CFG, rx_pkg::word_t'(c));
      for (int r = 0; r < 2; r++) begin
         write_reg(rx_pkg::REG_TESTDATA, (r == 0) ? 32'd0 : rand_word());   // restart sum
         for (int n = 0; n < N_RAND / 2; n++)
            send_access(rand_word(), rand_word());
         read_check(rx_pkg::REG_TESTDATA, m_testdata, "test data sum");
      end
      read_check(rx_pkg::REG_STATUS, {16'd0, m_status}, "test access status bit");
      write_reg(rx_pkg::REG_CFG, 32'd0);
   endtask

   task automatic test_status();
      rx_pkg::word_t v;
      write_reg(rx_pkg::REG_STATUS, rand_word());
      read_check(rx_pkg::REG_STATUS, {16'd0, m_status}, "status write");
      write_reg(rx_pkg::REG_STATUS, 32'd0);
      for (int n = 0; n < N_RAND / 4; n++) begin
         v          = rand_word();
         ext_status = v[13:0] & v[29:16] & v[31:18];   // sparse pulses
         m_status   = m_status | {ext_status, 2'b00};
         @(negedge clk);
         ext_status = '0;
         if (v[14])
            @(negedge clk);
      end
      read_check(rx_pkg::REG_STATUS, {16'd0, m_status}, "sticky status");
      write_reg(rx_pkg::REG_STATUS, rand_word());
      read_check(rx_pkg::REG_STATUS, {16'd0, m_status}, "status replace");
   endtask

   task automatic test_timeout();
      rx_pkg::rx_cfg_t c;
      c           = '0;
      c.timer_cfg = 2'd1;
      write_reg(rx_pkg::REG_STATUS, 32'd0);
      write_reg(rx_pkg::REG_CFG, rx_pkg::word_t'(c));
      repeat (idle_limit(2'd1) + 16) @(negedge clk);   // idle past the limit
      m_status[0] = 1'b1;
      read_check(rx_pkg::REG_STATUS, {16'd0, m_status}, "timeout status set");
      send_access(rand_word(), rand_word());
      write_reg(rx_pkg::REG_STATUS, 32'd0);
      for (int n = 0; n < 4; n++) begin
         repeat (idle_limit(2'd1) - 14) @(negedge clk);   // access every 50 cycles
         send_access(rand_word(), rand_word());
      end
      read_check(rx_pkg::REG_STATUS, {16'd0, m_status}, "timeout status clear");
      write_reg(rx_pkg::REG_CFG, 32'd0);
   endtask

   task automatic test_taps();
      for (int n = 0; n < N_RAND / 4; n++) begin
         write_reg(rx_pkg::REG_IDELAY0, rand_word());
         check_word({31'd0, load_taps}, 32'd0, "load_taps after word 0");
         write_reg(rx_pkg::REG_IDELAY1, rand_word());
         check_word({31'd0, load_taps}, 32'd1, "load_taps after word 1");
         check_taps(idelay_value, expect_taps(), "idelay_value");
         @(negedge clk);
         check_word({31'd0, load_taps}, 32'd0, "load_taps pulse end");
      end
      read_check(rx_pkg::REG_IDELAY0, 32'd0, "tap word 0 readback");
      read_check(rx_pkg::REG_IDELAY1, 32'd0, "tap word 1 readback");
   endtask

   //##########################################################################
   // sequence and watchdog
   //##########################################################################
   initial begin
      seed        = 32'h2d6a_c5f4;
      clk         = 1'b0;
      nreset      = 1'b0;
      mi_en       = 1'b0;
      mi_we       = 1'b0;
      mi_addr     = '0;
      mi_din      = '0;
      rx_in       = '0;
      gpio_datain = '0;
      ext_status  = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      nreset = 1'b1;
      test_registers();
      test_remap();
      test_mode_accum();
      test_status();
      test_timeout();
      test_taps();
      $display("TEST RESULT: PASS");
      $finish;
   end

   initial begin
      #((TEST_CYCLES + 2000) * 8);
      $display("watchdog expired, the test did not finish");
      stop_on_error();
   end

endmodule

// ==== design/rx_cfg.sv ====
// rx configuration register file on the simple memory interface
// holds config, remap base, taps, sticky status, gpio and test sum

`timescale 1ns/100ps

module rx_cfg (
   input  logic               clk,
   input  logic               nreset,
   // memory interface
   input  logic               mi_en,
   input  logic               mi_we,         // 1 = write, 0 = read
   input  rx_pkg::mi_addr_t   mi_addr,
   input  rx_pkg::word_t      mi_din,
   output rx_pkg::word_t      mi_dout,       // valid the cycle after a read
   // test path from remap
   input  logic               test_access,
   input  rx_pkg::word_t      test_data,
   // sampled inputs
   input  rx_pkg::gpio_t      gpio_datain,
   input  rx_pkg::status_t    rx_status,
   // configuration
   output rx_pkg::rx_cfg_t    cfg,
   output rx_pkg::word_t      remap_base,
   output rx_pkg::taps_t      idelay_value,
   output logic               load_taps
);

   logic                          wr_en;
   logic                          rd_en;
   logic [rx_pkg::REG_IDX_W-1:0]  reg_idx;

   logic                          cfg_wr;
   logic                          offset_wr;
   logic                          idelay0_wr;
   logic                          idelay1_wr;
   logic                          testdata_wr;
   logic                          status_wr;

   rx_pkg::taps_t                 idelay_q;     // raw tap words, 13 + 32 bits
   rx_pkg::status_t               status_q;
   rx_pkg::gpio_t                 gpio_q;
   rx_pkg::word_t                 testdata_q;

   //##########################################################################
   // address decode
   //##########################################################################
   assign wr_en   = mi_en & mi_we;
   assign rd_en   = mi_en & ~mi_we;
   assign reg_idx = mi_addr[rx_pkg::REG_IDX_W+1:2];   // word address

   assign cfg_wr      = wr_en & (reg_idx == rx_pkg::REG_CFG);
   assign offset_wr   = wr_en & (reg_idx == rx_pkg::REG_OFFSET);
   assign idelay0_wr  = wr_en & (reg_idx == rx_pkg::REG_IDELAY0);
   assign idelay1_wr  = wr_en & (reg_idx == rx_pkg::REG_IDELAY1);
   assign testdata_wr = wr_en & (reg_idx == rx_pkg::REG_TESTDATA);
   assign status_wr   = wr_en & (reg_idx == rx_pkg::REG_STATUS);

   //##########################################################################
   // registers
   //##########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cfg        <= '0;
         remap_base <= '0;
         idelay_q   <= '0;
         load_taps  <= 1'b0;
         gpio_q     <= '0;
         status_q   <= '0;
         testdata_q <= '0;
      end else begin
         if (cfg_wr)
            cfg <= rx_pkg::rx_cfg_t'(mi_din);
         if (offset_wr)
            remap_base <= mi_din;

         // tap words, high word carries frame low nibble + all msbs
         if (idelay0_wr)
            idelay_q[31:0] <= mi_din;
         if (idelay1_wr)
            idelay_q[44:32] <= mi_din[12:0];
         load_taps <= idelay1_wr;                 // one cycle after word 1 write

         gpio_q <= gpio_datain;                   // free-running sample

         // sticky status, write replaces
         if (status_wr)
            status_q <= mi_din[rx_pkg::STATUS_W-1:0];
         else
            status_q <= status_q | rx_status;

         // test accumulator, write wins over an access
         if (testdata_wr)
            testdata_q <= mi_din;
         else if (test_access)
            testdata_q <= testdata_q + test_data;
      end
   end

   //##########################################################################
   // tap arrangement: msb from word 1 bits 36..44, low nibble from word 0
   //##########################################################################
   always_comb begin
      for (int i = 0; i < 8; i++) begin
         idelay_value[5*i +: 5] = {idelay_q[36+i], idelay_q[4*i +: 4]};   // d0..d7
      end
      idelay_value[44:40] = {idelay_q[44], idelay_q[35:32]};              // frame
   end

   //##########################################################################
   // readback, one pipeline stage
   //##########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         mi_dout <= '0;
      end else if (rd_en) begin
         case (reg_idx)
            rx_pkg::REG_CFG:      mi_dout <= rx_pkg::word_t'(cfg);
            rx_pkg::REG_OFFSET:   mi_dout <= remap_base;
            rx_pkg::REG_TESTDATA: mi_dout <= testdata_q;
            rx_pkg::REG_GPIO:
               mi_dout <= {{(rx_pkg::REG_W-rx_pkg::GPIO_W){1'b0}}, gpio_q};
            rx_pkg::REG_STATUS:
               mi_dout <= {{(rx_pkg::REG_W-rx_pkg::STATUS_W){1'b0}}, status_q};
            default:              mi_dout <= '0;   // taps and unmapped
         endcase
      end else begin
         mi_dout <= '0;                            // idle cycles read zero
      end
   end

endmodule

// ==== design/rx_pkg.sv ====
// rx link configuration package
// register map, widths, vector types and the config/access structs

package rx_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths
   localparam int REG_W     = 32;    // register and address word
   localparam int GPIO_W    = 9;     // frame + 8 data pins
   localparam int STATUS_W  = 16;
   localparam int REG_IDX_W = 4;     // word index, mi_addr[5:2]

   //##########################################################################
   // register map (word index)
   //##########################################################################
   localparam logic [REG_IDX_W-1:0] REG_CFG      = 4'd0;
   localparam logic [REG_IDX_W-1:0] REG_OFFSET   = 4'd1;   // dynamic remap base
   localparam logic [REG_IDX_W-1:0] REG_IDELAY0  = 4'd2;   // taps, low word (write only)
   localparam logic [REG_IDX_W-1:0] REG_IDELAY1  = 4'd3;   // taps, high 13 bits (write only)
   localparam logic [REG_IDX_W-1:0] REG_TESTDATA = 4'd4;
   localparam logic [REG_IDX_W-1:0] REG_GPIO     = 4'd5;
   localparam logic [REG_IDX_W-1:0] REG_STATUS   = 4'd6;

   // idle timeout limits, selected by timer_cfg 1..3
   localparam logic [9:0] TIMEOUT_LIMIT_1 = 10'd63;
   localparam logic [9:0] TIMEOUT_LIMIT_2 = 10'd255;
   localparam logic [9:0] TIMEOUT_LIMIT_3 = 10'd1023;

   //##########################################################################
   // types
   //##########################################################################
   typedef logic [REG_W-1:0]    word_t;
   typedef logic [14:0]         mi_addr_t;   // byte address
   typedef logic [STATUS_W-1:0] status_t;
   typedef logic [GPIO_W-1:0]   gpio_t;
   typedef logic [44:0]         taps_t;      // 9 x 5 bits: frame, d7 .. d0

   typedef enum logic [1:0] {
      REMAP_NONE    = 2'b00,
      REMAP_STATIC  = 2'b01,
      REMAP_DYNAMIC = 2'b10,
      REMAP_RSVD    = 2'b11   // treated as none
   } remap_mode_t;

   // matches REG_CFG bit for bit, msb first
   typedef struct packed {
      logic        rsvd;
      logic [1:0]  timer_cfg;        // 0 = timeout off
      logic        mailbox_irq_en;
      logic [11:0] remap_pattern;    // replaces addr[31:20] where sel set
      logic [11:0] remap_sel;
      remap_mode_t remap_mode;
      logic        mmu_enable;
      logic        test_mode;        // divert accesses to accumulator
   } rx_cfg_t;

   // one access on the rx stream, single-cycle strobe
   typedef struct packed {
      logic  valid;
      word_t addr;
      word_t data;
   } rx_access_t;

endpackage

// ==== design/rx_remap.sv ====
// rx address remap, static bit replace or dynamic base add
// registers each access one cycle; test mode diverts to the accumulator

`timescale 1ns/100ps

module rx_remap (
   input  logic                clk,
   input  logic                nreset,
   input  rx_pkg::rx_access_t  rx_in,
   input  rx_pkg::rx_cfg_t     cfg,
   input  rx_pkg::word_t       remap_base,
   output rx_pkg::rx_access_t  rx_out,
   output logic                test_access,   // same cycle as rx_in
   output rx_pkg::word_t       test_data
);

   rx_pkg::word_t  static_addr;
   rx_pkg::word_t  remap_addr;
   logic           fwd;                        // access goes downstream

   //##########################################################################
   // address rewrite
   //##########################################################################
   // static: replace addr[31:20] bits where sel is set
   assign static_addr = {(rx_in.addr[31:20] & ~cfg.remap_sel) |
                         (cfg.remap_pattern & cfg.remap_sel),
                         rx_in.addr[19:0]};

   always_comb begin
      case (cfg.remap_mode)
         rx_pkg::REMAP_STATIC:  remap_addr = static_addr;
         rx_pkg::REMAP_DYNAMIC: remap_addr = rx_in.addr + remap_base;   // wraps at 2^32
         default:               remap_addr = rx_in.addr;                // none, rsvd
      endcase
   end

   //##########################################################################
   // test mode diversion
   //##########################################################################
   assign fwd         = rx_in.valid & ~cfg.test_mode;
   assign test_access = rx_in.valid &  cfg.test_mode;
   assign test_data   = rx_in.data;

   //##########################################################################
   // output stage
   //##########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rx_out <= '0;
      end else begin
         rx_out.valid <= fwd;                  // one-cycle strobe
         if (fwd) begin
            rx_out.addr <= remap_addr;
            rx_out.data <= rx_in.data;         // data untouched
         end
      end
   end

endmodule

// ==== design/rx_timeout.sv ====
// rx idle timeout, counts cycles without a valid access
// pulses timeout when the count hits the limit chosen by timer_cfg

`timescale 1ns/100ps

module rx_timeout (
   input  logic        clk,
   input  logic        nreset,
   input  logic        rx_in_valid,
   input  logic [1:0]  timer_cfg,    // 0 = off
   output logic        timeout
);

   logic [9:0]  idle_cnt;
   logic [9:0]  limit;

   // limit select
   always_comb begin
      case (timer_cfg)
         2'd1:    limit = rx_pkg::TIMEOUT_LIMIT_1;
         2'd2:    limit = rx_pkg::TIMEOUT_LIMIT_2;
         2'd3:    limit = rx_pkg::TIMEOUT_LIMIT_3;
         default: limit = '0;                      // off, counter held
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         idle_cnt <= '0;
         timeout  <= 1'b0;
      end else if (rx_in_valid || (timer_cfg == 2'd0)) begin
         idle_cnt <= '0;                           // activity or disabled
         timeout  <= 1'b0;
      end else if (idle_cnt == limit) begin
         idle_cnt <= '0;                           // restart after pulse
         timeout  <= 1'b1;
      end else begin
         idle_cnt <= idle_cnt + 10'd1;
         timeout  <= 1'b0;
      end
   end

endmodule

// ==== design/rx_top.sv ====
// rx configuration and address path top
// register file, address remap and idle timeout

`timescale 1ns/100ps

module rx_top (
   input  logic                                clk,
   input  logic                                nreset,
   // memory interface
   input  logic                                mi_en,
   input  logic                                mi_we,
   input  rx_pkg::mi_addr_t                    mi_addr,
   input  rx_pkg::word_t                       mi_din,
   output rx_pkg::word_t                       mi_dout,
   // access stream
   input  rx_pkg::rx_access_t                  rx_in,
   output rx_pkg::rx_access_t                  rx_out,
   // status and pins
   input  rx_pkg::gpio_t                       gpio_datain,
   input  logic [rx_pkg::STATUS_W-3:0]         ext_status,   // 14 bits
   // config out
   output logic                                mmu_enable,
   output logic                                mailbox_irq_en,
   output rx_pkg::taps_t                       idelay_value,
   output logic                                load_taps
);

   rx_pkg::rx_cfg_t  cfg;
   rx_pkg::word_t    remap_base;
   rx_pkg::word_t    test_data;
   rx_pkg::status_t  rx_status;
   logic             test_access;
   logic             timeout;

   assign mmu_enable     = cfg.mmu_enable;
   assign mailbox_irq_en = cfg.mailbox_irq_en;

   // timeout in bit 0, test access bit 1
   assign rx_status = {ext_status, test_access, timeout};

   //##########################################################################
   // blocks
   //##########################################################################
   rx_cfg i_cfg (
      .clk          (clk),
      .nreset       (nreset),
      .mi_en        (mi_en),
      .mi_we        (mi_we),
      .mi_addr      (mi_addr),
      .mi_din       (mi_din),
      .mi_dout      (mi_dout),
      .test_access  (test_access),
      .test_data    (test_data),
      .gpio_datain  (gpio_datain),
      .rx_status    (rx_status),
      .cfg          (cfg),
      .remap_base   (remap_base),
      .idelay_value (idelay_value),
      .load_taps    (load_taps)
   );

   rx_remap i_remap (
      .clk         (clk),
      .nreset      (nreset),
      .rx_in       (rx_in),
      .cfg         (cfg),
      .remap_base  (remap_base),
      .rx_out      (rx_out),
      .test_access (test_access),
      .test_data   (test_data)
   );

   rx_timeout i_timeout (
      .clk         (clk),
      .nreset      (nreset),
      .rx_in_valid (rx_in.valid),
      .timer_cfg   (cfg.timer_cfg),
      .timeout     (timeout)
   );

endmodule
